/* hdl/dram_fifo_pkg.sv */
//--------------------------------------------------
// dual stream FIFO shared definitions
// widths, region map and the beat and request types
//--------------------------------------------------

package dram_fifo_pkg;

  //--------------------------------------------------
  // widths and region map
  //--------------------------------------------------
  localparam int DATA_W     = 64;                     // stream data width
  localparam int NUM_CHAN   = 2;                      // fifo channels sharing the ram
  localparam int CHAN_W     = $clog2(NUM_CHAN);       // channel index width
  localparam int FIFO_DEPTH = 64;                     // words per channel region
  localparam int PTR_W      = $clog2(FIFO_DEPTH);     // pointer inside one region
  localparam int ADDR_W     = 7;                      // covers NUM_CHAN*FIFO_DEPTH
  localparam int MEM_WORDS  = NUM_CHAN * FIFO_DEPTH;  // total ram words
  localparam int OB_DEPTH   = 2;                      // output buffer entries per channel

  //--------------------------------------------------
  // stream beat, also the word kept in the ram
  //--------------------------------------------------
  typedef struct packed {
    logic [DATA_W-1:0] data;  // payload
    logic              last;  // end of packet
  } axis_beat_t;

  // one channel's request to the shared ram
  typedef struct packed {
    logic              req;    // level, held until granted
    logic              we;     // 1 write, 0 read
    logic [ADDR_W-1:0] addr;   // absolute ram address
    axis_beat_t        wbeat;  // write payload
  } mem_req_t;

endpackage

/* hdl/shared_sram.sv */
//--------------------------------------------------
// single-port ram holding every channel's region
//--------------------------------------------------

`timescale 1ns/1ps

module shared_sram
  import dram_fifo_pkg::*;
(
  input  logic              ddr3_axi_clk,
  input  logic              i_en,     // access this cycle
  input  logic              i_we,     // 1 write, 0 read
  input  logic [ADDR_W-1:0] i_addr,
  input  axis_beat_t        i_wbeat,
  output axis_beat_t        o_rbeat   // valid one cycle after a read
);

  axis_beat_t mem [MEM_WORDS];  // region c at c*FIFO_DEPTH

  always_ff @(posedge ddr3_axi_clk) begin
    if (i_en) begin
      if (i_we) begin
        mem[i_addr] <= i_wbeat;  // lands at the granted edge
      end else begin
        o_rbeat <= mem[i_addr];  // registered read
      end
    end
  end

endmodule

/* hdl/mem_arbiter.sv */
//--------------------------------------------------
// round-robin arbiter for the shared ram port
// grants one channel per cycle, routes read data back
//--------------------------------------------------

`timescale 1ns/1ps

module mem_arbiter
  import dram_fifo_pkg::*;
(
  input  logic                ddr3_axi_clk,
  input  logic                i_reset,
  input  mem_req_t            i_req [NUM_CHAN],  // one request per channel
  output logic [NUM_CHAN-1:0] o_grant,           // combinational strobe
  output logic [NUM_CHAN-1:0] o_rd_valid,        // one cycle after a read grant
  output axis_beat_t          o_rd_beat,
  // ram port
  output logic                o_mem_en,
  output logic                o_mem_we,
  output logic [ADDR_W-1:0]   o_mem_addr,
  output axis_beat_t          o_mem_wbeat,
  input  axis_beat_t          i_mem_rbeat
);

  logic [CHAN_W-1:0]   last_q;    // last winner
  logic [CHAN_W-1:0]   sel;       // granted channel this cycle
  logic                found;
  logic [NUM_CHAN-1:0] rd_ret_q;  // whose read is on the ram output

  //--------------------------------------------------
  // grant, search starts after the last winner
  //--------------------------------------------------
  always_comb begin
    int idx;
    o_grant = '0;
    sel     = '0;
    found   = 1'b0;
    for (int k = 1; k <= NUM_CHAN; k++) begin
      idx = (int'(last_q) + k) % NUM_CHAN;
      if (!found && i_req[idx].req) begin
        o_grant[idx] = 1'b1;
        sel          = CHAN_W'(idx);
        found        = 1'b1;
      end
    end
  end

  // granted request onto the ram port
  assign o_mem_en    = found;
  assign o_mem_we    = found & i_req[sel].we;
  assign o_mem_addr  = i_req[sel].addr;
  assign o_mem_wbeat = i_req[sel].wbeat;

  always_ff @(posedge ddr3_axi_clk) begin
    if (i_reset) begin
      last_q   <= CHAN_W'(NUM_CHAN - 1);  // channel 0 first after reset
      rd_ret_q <= '0;
    end else begin
      if (found) begin
        last_q <= sel;
      end
      rd_ret_q <= (found && !i_req[sel].we) ? o_grant : '0;  // tag the read
    end
  end

  // read return, beat shared, valid per channel
  assign o_rd_valid = rd_ret_q;
  assign o_rd_beat  = i_mem_rbeat;

endmodule

/* hdl/fifo_channel.sv */
//--------------------------------------------------
// one fifo channel over a fixed ram region
// write staging, pointers, read prefetch, out buffer
//--------------------------------------------------

`timescale 1ns/1ps

module fifo_channel
  import dram_fifo_pkg::*;
#(
  parameter int CHAN_ID = 0  // selects the region, base is CHAN_ID*FIFO_DEPTH
) (
  input  logic       ddr3_axi_clk,
  input  logic       i_reset,
  // input stream
  input  axis_beat_t i_in_beat,
  input  logic       i_in_valid,
  output logic       o_in_ready,
  // output stream
  output axis_beat_t o_out_beat,
  output logic       o_out_valid,
  input  logic       i_out_ready,
  // shared ram access through the arbiter
  output mem_req_t   o_mem_req,
  input  logic       i_grant,     // one-cycle strobe, same cycle as the request
  input  logic       i_rd_valid,  // our read beat is on i_rd_beat
  input  axis_beat_t i_rd_beat
);

  //--------------------------------------------------
  // declarations
  //--------------------------------------------------
  logic [ADDR_W-1:0] base_addr;        // start of this channel's region
  axis_beat_t        stg_beat;         // staging register
  logic              stg_full;
  logic [PTR_W-1:0]  wr_ptr;           // next word to write
  logic [PTR_W-1:0]  rd_ptr;           // next word to read
  logic [PTR_W:0]    word_cnt;         // words held in the region, 0..FIFO_DEPTH
  axis_beat_t        ob_mem [OB_DEPTH];
  logic              ob_wr_idx;
  logic              ob_rd_idx;
  logic [1:0]        ob_cnt;           // 0..2 beats waiting at the output
  logic [1:0]        ob_occ;           // buffer plus read in flight
  logic              rd_want;
  logic              wr_want;
  logic              wait_q;           // request seen but not granted last cycle
  logic              held_rd_q;        // op type of that waiting request
  logic              op_rd;            // op requested this cycle is a read
  logic              req;
  logic              rd_grant;
  logic              wr_grant;
  logic              ob_push;
  logic              ob_pop;

  assign base_addr = ADDR_W'(CHAN_ID * FIFO_DEPTH);

  //--------------------------------------------------
  // request selection
  //--------------------------------------------------
  // a read is in flight exactly while i_rd_valid is high
  assign ob_occ  = ob_cnt + {1'b0, i_rd_valid};
  assign rd_want = (word_cnt != '0) && (ob_occ < OB_DEPTH);       // prefetch first
  assign wr_want = stg_full && (word_cnt < (PTR_W+1)'(FIFO_DEPTH)); // room in region

  // a waiting request keeps its type, the other fields only move on a grant
  assign op_rd = wait_q ? held_rd_q : rd_want;
  assign req   = wait_q | rd_want | wr_want;

  assign o_mem_req.req   = req;
  assign o_mem_req.we    = ~op_rd;
  assign o_mem_req.addr  = base_addr + ADDR_W'(op_rd ? rd_ptr : wr_ptr);
  assign o_mem_req.wbeat = stg_beat;

  assign rd_grant = i_grant & op_rd;
  assign wr_grant = i_grant & ~op_rd;

  always_ff @(posedge ddr3_axi_clk) begin
    if (i_reset) begin
      wait_q    <= 1'b0;
      held_rd_q <= 1'b0;
    end else begin
      wait_q    <= req & ~i_grant;  // lost arbitration, hold it
      held_rd_q <= op_rd;
    end
  end

  //--------------------------------------------------
  // input staging
  //--------------------------------------------------
  assign o_in_ready = ~stg_full;  // one beat deep

  always_ff @(posedge ddr3_axi_clk) begin
    if (i_reset) begin
      stg_full <= 1'b0;
    end else if (i_in_valid && o_in_ready) begin
      stg_full <= 1'b1;
    end else if (wr_grant) begin
      stg_full <= 1'b0;  // beat moved into the ram
    end
  end

  always_ff @(posedge ddr3_axi_clk) begin
    if (i_in_valid && o_in_ready) begin
      stg_beat <= i_in_beat;
    end
  end

  //--------------------------------------------------
  // region pointers and count
  //--------------------------------------------------
  always_ff @(posedge ddr3_axi_clk) begin
    if (i_reset) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      word_cnt <= '0;
    end else begin
      if (wr_grant) begin
        wr_ptr   <= wr_ptr + 1'b1;    // wraps at region end
        word_cnt <= word_cnt + 1'b1;
      end
      if (rd_grant) begin
        rd_ptr   <= rd_ptr + 1'b1;
        word_cnt <= word_cnt - 1'b1;  // one op per cycle, never both
      end
    end
  end

  //--------------------------------------------------
  // output buffer
  //--------------------------------------------------
  assign ob_push     = i_rd_valid;
  assign ob_pop      = o_out_valid & i_out_ready;
  assign o_out_valid = (ob_cnt != 2'd0);
  assign o_out_beat  = ob_mem[ob_rd_idx];

  always_ff @(posedge ddr3_axi_clk) begin
    if (i_reset) begin
      ob_wr_idx <= 1'b0;
      ob_rd_idx <= 1'b0;
      ob_cnt    <= 2'd0;
    end else begin
      if (ob_push) begin
        ob_wr_idx <= ~ob_wr_idx;
      end
      if (ob_pop) begin
        ob_rd_idx <= ~ob_rd_idx;
      end
      case ({ob_push, ob_pop})
        2'b10:   ob_cnt <= ob_cnt + 2'd1;
        2'b01:   ob_cnt <= ob_cnt - 2'd1;
        default: ob_cnt <= ob_cnt;  // idle or push and pop together
      endcase
    end
  end

  always_ff @(posedge ddr3_axi_clk) begin
    if (ob_push) begin
      ob_mem[ob_wr_idx] <= i_rd_beat;
    end
  end

endmodule

/* hdl/dram_fifo_dual.sv */
//--------------------------------------------------
// dual-channel stream fifo over one shared ram
// two channels, a round-robin arbiter and the ram
//--------------------------------------------------

`timescale 1ns/1ps

module dram_fifo_dual
  import dram_fifo_pkg::*;
(
  input  logic                ddr3_axi_clk,
  input  logic                i_reset,
  // input streams
  input  axis_beat_t          i_in_beat [NUM_CHAN],
  input  logic [NUM_CHAN-1:0] i_in_valid,
  output logic [NUM_CHAN-1:0] o_in_ready,
  // output streams
  output axis_beat_t          o_out_beat [NUM_CHAN],
  output logic [NUM_CHAN-1:0] o_out_valid,
  input  logic [NUM_CHAN-1:0] i_out_ready
);

  //--------------------------------------------------
  // channel to arbiter to ram wiring
  //--------------------------------------------------
  mem_req_t            chan_req [NUM_CHAN];  // one request per channel
  logic [NUM_CHAN-1:0] grant;
  logic [NUM_CHAN-1:0] rd_valid;
  axis_beat_t          rd_beat;              // shared read return
  logic                mem_en;
  logic                mem_we;
  logic [ADDR_W-1:0]   mem_addr;
  axis_beat_t          mem_wbeat;
  axis_beat_t          mem_rbeat;

  for (genvar c = 0; c < NUM_CHAN; c++) begin : g_chan
    fifo_channel #(
      .CHAN_ID (c)
    ) u_chan (
      .ddr3_axi_clk (ddr3_axi_clk),
      .i_reset      (i_reset),
      .i_in_beat    (i_in_beat[c]),
      .i_in_valid   (i_in_valid[c]),
      .o_in_ready   (o_in_ready[c]),
      .o_out_beat   (o_out_beat[c]),
      .o_out_valid  (o_out_valid[c]),
      .i_out_ready  (i_out_ready[c]),
      .o_mem_req    (chan_req[c]),
      .i_grant      (grant[c]),
      .i_rd_valid   (rd_valid[c]),
      .i_rd_beat    (rd_beat)
    );
  end

  mem_arbiter u_arb (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_reset      (i_reset),
    .i_req        (chan_req),
    .o_grant      (grant),
    .o_rd_valid   (rd_valid),
    .o_rd_beat    (rd_beat),
    .o_mem_en     (mem_en),
    .o_mem_we     (mem_we),
    .o_mem_addr   (mem_addr),
    .o_mem_wbeat  (mem_wbeat),
    .i_mem_rbeat  (mem_rbeat)
  );

  shared_sram u_sram (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_en         (mem_en),
    .i_we         (mem_we),
    .i_addr       (mem_addr),
    .i_wbeat      (mem_wbeat),
    .o_rbeat      (mem_rbeat)
  );

endmodule

/* bench/tb_checker.sv */
//--------------------------------------------------
// stream checker for the dual-channel fifo
// reference queues fed by input transfers, compared on output
//--------------------------------------------------

`timescale 1ns/1ps

module tb_checker
  import dram_fifo_pkg::*;
(
  input  logic                ddr3_axi_clk,
  input  logic                i_reset,
  input  axis_beat_t          i_in_beat [NUM_CHAN],
  input  logic [NUM_CHAN-1:0] i_in_valid,
  input  logic [NUM_CHAN-1:0] i_in_ready,
  input  axis_beat_t          i_out_beat [NUM_CHAN],
  input  logic [NUM_CHAN-1:0] i_out_valid,
  input  logic [NUM_CHAN-1:0] i_out_ready,
  output int                  o_pending [NUM_CHAN],  // beats accepted but not yet out
  output int                  o_err_cnt
);

  axis_beat_t exp_q0 [$];  // channel 0, oldest first
  axis_beat_t exp_q1 [$];  // channel 1
  int         n_checked;   // output beats compared so far
  int         err_stream;  // errors seen on the streams
  int         err_misc;    // errors flagged by the stimulus side
  int         mark_checked;
  int         mark_err;

  assign o_err_cnt = err_stream + err_misc;

  // reference model, next beat out is the oldest one accepted, unchanged
  function automatic axis_beat_t expected_beat(input int c);
    return (c == 0) ? exp_q0[0] : exp_q1[0];
  endfunction

  function automatic int queued(input int c);
    return (c == 0) ? exp_q0.size() : exp_q1.size();
  endfunction

  //--------------------------------------------------
  // watch both streams of every channel
  //--------------------------------------------------
  always @(posedge ddr3_axi_clk) begin
    axis_beat_t want;
    if (!i_reset) begin
      for (int c = 0; c < NUM_CHAN; c++) begin
        if (i_in_valid[c] && i_in_ready[c]) begin  // input transfer
          if (c == 0) begin
            exp_q0.push_back(i_in_beat[c]);
          end else begin
            exp_q1.push_back(i_in_beat[c]);
          end
        end
        if (i_out_valid[c] && i_out_ready[c]) begin  // output transfer
          if (queued(c) == 0) begin
            $display("channel %0d sent a beat at time %0t with nothing expected", c, $time);
            err_stream++;
          end else begin
            want = expected_beat(c);
            if (c == 0) begin
              void'(exp_q0.pop_front());
            end else begin
              void'(exp_q1.pop_front());
            end
            n_checked++;
            if (i_out_beat[c] !== want) begin
              $display("Mismatch at time %0t: channel %0d got data %h last %b, expected %h last %b",
                       $time, c, i_out_beat[c].data, i_out_beat[c].last, want.data, want.last);
              err_stream++;
            end
          end
        end
        o_pending[c] = queued(c);
      end
    end
  end

  //--------------------------------------------------
  // calls from the stimulus side
  //--------------------------------------------------
  task automatic check_idle();
    if (i_out_valid != '0) begin
      $display("output valid is high right after reset");
      err_misc++;
    end
    if (i_in_ready != '1) begin
      $display("input ready is low right after reset");
      err_misc++;
    end
  endtask

  task automatic flag_error(input string msg);
    $display("%s", msg);
    err_misc++;
  endtask

  task automatic end_test(input string name);
    $display("test %s finished: %0d beats checked, %0d errors",
             name, n_checked - mark_checked, err_stream + err_misc - mark_err);
    mark_checked = n_checked;
    mark_err     = err_stream + err_misc;
  endtask

  task automatic report_totals();
    $display("totals: %0d beats checked, %0d errors", n_checked, err_stream + err_misc);
  endtask

endmodule

/* bench/tb_dram_fifo_dual.sv */
//--------------------------------------------------
// testbench for the dual-channel stream fifo
// clock, reset, stream stimulus and run watchdog
//--------------------------------------------------

`timescale 1ns/1ps

module tb_dram_fifo_dual
  import dram_fifo_pkg::*;
();

  localparam int N_SOLO      = 40;   // channel 0 alone
  localparam int N_BOTH      = 50;   // per channel, both at once
  localparam int N_BP0       = 40;   // channel 0 while channel 1 is blocked
  localparam int N_BP1_MAX   = 80;   // cap on the channel 1 fill
  localparam int N_RAND      = 300;  // per channel, random traffic
  localparam int STALL_LIM   = 20;   // ready low this long means full
  localparam int TOTAL_BEATS = N_SOLO + 2*N_BOTH + N_BP0 + N_BP1_MAX + 1 + 2*N_RAND;
  localparam int CYCLE_LIMIT = 20*TOTAL_BEATS + 2000;
  localparam int PAT_SOLO    = 1;
  localparam int PAT_A       = 2;
  localparam int PAT_B       = 3;
  localparam int PAT_C       = 4;
  localparam int PAT_D       = 5;
  localparam int PAT_RAND    = 6;

  logic                ddr3_axi_clk;
  logic                reset;
  axis_beat_t          in_beat [NUM_CHAN];
  logic [NUM_CHAN-1:0] in_valid;
  logic [NUM_CHAN-1:0] in_ready;
  axis_beat_t          out_beat [NUM_CHAN];
  logic [NUM_CHAN-1:0] out_valid;
  logic [NUM_CHAN-1:0] out_ready;
  int                  pending [NUM_CHAN];
  int                  err_cnt;
  int                  seed;
  int                  cycle_cnt;
  int                  bp_accepted;
  logic                rand_done;

  dram_fifo_dual i_dut (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_reset      (reset),
    .i_in_beat    (in_beat),
    .i_in_valid   (in_valid),
    .o_in_ready   (in_ready),
    .o_out_beat   (out_beat),
    .o_out_valid  (out_valid),
    .i_out_ready  (out_ready)
  );

  tb_checker u_chk (
    .ddr3_axi_clk (ddr3_axi_clk),
    .i_reset      (reset),
    .i_in_beat    (in_beat),
    .i_in_valid   (in_valid),
    .i_in_ready   (in_ready),
    .i_out_beat   (out_beat),
    .i_out_valid  (out_valid),
    .i_out_ready  (out_ready),
    .o_pending    (pending),
    .o_err_cnt    (err_cnt)
  );

  initial begin
    ddr3_axi_clk = 1'b0;
    forever #10 ddr3_axi_clk = ~ddr3_axi_clk;  // 20 ns period
  end

  always @(posedge ddr3_axi_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout after %0d cycles, %0d beats never came out",
               cycle_cnt, pending[0] + pending[1]);
      $display("Test failed");
      $finish;
    end
  end

  //--------------------------------------------------
  // stimulus helpers
  //--------------------------------------------------
  function automatic axis_beat_t make_beat(input int c, input int pat, input int i);
    axis_beat_t b;
    if (pat == PAT_RAND) begin
      b.data = {32'($random(seed)), 32'($random(seed))};
      b.last = 1'($random(seed));
    end else begin
      b.data = {8'(pat), 8'(c), 16'(i), 32'(i) * 32'h9E37_79B9};  // tagged per test and channel
      b.last = ((i + 1) % (pat + 3)) == 0;
    end
    return b;
  endfunction

  // n beats on channel c, optional random idle gaps between them
  task automatic send_stream(input int c, input int n, input int pat, input bit gaps);
    for (int i = 0; i < n; i++) begin
      @(negedge ddr3_axi_clk);
      if (gaps) begin
        while (($random(seed) & 3) == 0) begin
          in_valid[c] = 1'b0;
          @(negedge ddr3_axi_clk);
        end
      end
      in_valid[c] = 1'b1;
      in_beat[c]  = make_beat(c, pat, i);
      do @(posedge ddr3_axi_clk); while (!in_ready[c]);  // held until taken
    end
    @(negedge ddr3_axi_clk);
    in_valid[c] = 1'b0;
  endtask

  // push channel 1 until its input stays blocked, last beat left pending
  task automatic fill_until_stall(output int accepted);
    int stall;
    accepted = 0;
    stall    = 0;
    @(negedge ddr3_axi_clk);
    in_valid[1] = 1'b1;
    in_beat[1]  = make_beat(1, PAT_D, 0);
    while (stall < STALL_LIM && accepted < N_BP1_MAX) begin
      @(posedge ddr3_axi_clk);
      if (in_ready[1]) begin
        accepted++;
        stall = 0;
        @(negedge ddr3_axi_clk);
        in_beat[1] = make_beat(1, PAT_D, accepted);
      end else begin
        stall++;
      end
    end
  endtask

  task automatic toggle_ready();
    while (!rand_done) begin
      @(negedge ddr3_axi_clk);
      out_ready[0] = (($random(seed) & 3) != 0);  // ready about 3 cycles in 4
      out_ready[1] = (($random(seed) & 3) != 0);
    end
    out_ready = '1;
  endtask

  task automatic wait_drain();
    while (pending[0] != 0 || pending[1] != 0) begin
      @(negedge ddr3_axi_clk);
    end
    repeat (5) @(negedge ddr3_axi_clk);  // room for a stray beat to show
  endtask

  //--------------------------------------------------
  // test sequence
  //--------------------------------------------------
  initial begin
    seed      = 32'h8c0;
    reset     = 1'b1;
    in_valid  = '0;
    out_ready = '0;
    rand_done = 1'b0;
    for (int c = 0; c < NUM_CHAN; c++) begin
      in_beat[c] = '0;
    end
    repeat (10) @(negedge ddr3_axi_clk);
    reset = 1'b0;

    @(negedge ddr3_axi_clk);
    u_chk.check_idle();
    u_chk.end_test("reset state");

    out_ready = '1;
    send_stream(0, N_SOLO, PAT_SOLO, 1'b0);
    wait_drain();
    u_chk.end_test("channel 0 alone");

    fork
      send_stream(0, N_BOTH, PAT_A, 1'b0);
      send_stream(1, N_BOTH, PAT_B, 1'b0);
    join
    wait_drain();
    u_chk.end_test("both channels");

    out_ready = 2'b01;  // channel 1 blocked at its output
    fork
      send_stream(0, N_BP0, PAT_C, 1'b0);
      fill_until_stall(bp_accepted);
    join
    do @(negedge ddr3_axi_clk); while (pending[0] != 0);  // channel 0 drains past the stall
    if (bp_accepted >= N_BP1_MAX) begin
      u_chk.flag_error("channel 1 input never stalled under back-pressure");
    end
    if (bp_accepted < FIFO_DEPTH) begin
      u_chk.flag_error($sformatf("channel 1 took only %0d beats before stalling",
                                 bp_accepted));
    end
    out_ready[1] = 1'b1;
    do @(posedge ddr3_axi_clk); while (!in_ready[1]);  // pending beat goes in
    @(negedge ddr3_axi_clk);
    in_valid[1] = 1'b0;
    wait_drain();
    u_chk.end_test("back-pressure");

    fork
      begin
        fork
          send_stream(0, N_RAND, PAT_RAND, 1'b1);
          send_stream(1, N_RAND, PAT_RAND, 1'b1);
        join
        rand_done = 1'b1;
      end
      toggle_ready();
    join
    wait_drain();
    u_chk.end_test("random traffic");

    u_chk.report_totals();
    @(negedge ddr3_axi_clk);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* project.f */
hdl/dram_fifo_pkg.sv
hdl/shared_sram.sv
hdl/mem_arbiter.sv
hdl/fifo_channel.sv
hdl/dram_fifo_dual.sv
bench/tb_checker.sv
bench/tb_dram_fifo_dual.sv

/* run_sim.sh */
#!/bin/sh
# build and run the dual fifo testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
  --top-module tb_dram_fifo_dual \
  -f project.f \
  -o tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "compile step failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1
